// File: bench/mpeg_sys_parser_properties.sv
// module mpeg_sys_parser_properties and its bind: strobe and reset assertions on the top level

`timescale 1ns/1ps

module mpeg_sys_parser_properties (
	input logic enable,
	input logic rst,
	input logic pack_done,
	input logic sys_done,
	input logic stream_valid
);

	logic strobes;

	assign strobes = pack_done | sys_done | stream_valid;

	strobes_in_reset: assert property (@(posedge enable) rst |=> !strobes)
		else $error("strobe active while reset is applied");

	strobes_after_reset: assert property (@(posedge enable) $fell(rst) |=> !strobes)
		else $error("strobe active in the cycle after reset");

	pack_done_pulse: assert property (@(posedge enable) disable iff (rst)
		pack_done |=> !pack_done)
		else $error("pack_done held for more than one cycle");

	sys_done_pulse: assert property (@(posedge enable) disable iff (rst)
		sys_done |=> !sys_done)
		else $error("sys_done held for more than one cycle");

	entry_apart_from_done: assert property (@(posedge enable) disable iff (rst)
		!(stream_valid && sys_done))
		else $error("stream_valid and sys_done in the same cycle");

endmodule

bind mpeg_sys_parser mpeg_sys_parser_properties mpeg_sys_parser_properties_inst (
	.enable       (enable),
	.rst          (rst),
	.pack_done    (pack_done),
	.sys_done     (sys_done),
	.stream_valid (stream_valid)
);

// File: bench/mpeg_sys_parser_tb.sv
// parser testbench with clock, reset, LFSR, stream builders, result monitor and directed tests

`timescale 1ns/1ps

module mpeg_sys_parser_tb;

	import mpeg_sys_pkg::*;

	logic          enable;
	logic          rst;
	logic          bit_in;
	logic          bit_valid;
	logic          pack_done;
	pack_info_t    pack_info;
	logic          sys_done;
	sys_info_t     sys_info;
	logic          stream_valid;
	stream_entry_t stream_entry;

	logic [31:0]   lfsr;
	int            checks;
	int            errors;
	int            start_cnt;    // detector start strobes seen
	pack_info_t    pack_q[$];
	sys_info_t     sys_q[$];
	stream_entry_t ent_q[$];
	int            order_q[$];   // 0 pack, 1 entry, 2 system header
	stream_entry_t ent_tab[4];   // entries of the header being sent

	mpeg_sys_parser mpeg_sys_parser_inst (
		.enable       (enable),
		.rst          (rst),
		.bit_in       (bit_in),
		.bit_valid    (bit_valid),
		.pack_done    (pack_done),
		.pack_info    (pack_info),
		.sys_done     (sys_done),
		.sys_info     (sys_info),
		.stream_valid (stream_valid),
		.stream_entry (stream_entry)
	);

	always #50 enable = ~enable;  // 100 ns period

	// result monitor on the falling edge
	always @(negedge enable) begin
		if (pack_done) begin
			pack_q.push_back(pack_info);
			order_q.push_back(0);
		end
		if (stream_valid) begin
			ent_q.push_back(stream_entry);
			order_q.push_back(1);
		end
		if (sys_done) begin
			sys_q.push_back(sys_info);
			order_q.push_back(2);
		end
		if (mpeg_sys_parser_inst.pack_start || mpeg_sys_parser_inst.sys_start)
			start_cnt++;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[62:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic compare_hex(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic require(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error: %s", what);
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge enable);
			#1;
		end
	endtask

	// starts and ends 1 ns after a rising edge
	task automatic send_bit(input logic b);
		int gap;
		gap = int'(rand_bits(2));  // 0 to 3 idle cycles
		bit_in    = b;
		bit_valid = 1'b1;
		@(posedge enable);
		#1;
		bit_valid = 1'b0;
		idle(gap);
	endtask

	task automatic send_byte(input byte_t b);
		for (int i = 7; i >= 0; i--)
			send_bit(b[i]);
	endtask

	task automatic send_prefix(input byte_t code);
		send_byte(8'h00);
		send_byte(8'h00);
		send_byte(8'h01);
		send_byte(code);
	endtask

	task automatic send_pack(input scr_t scr, input mux_rate_t mux, input logic bad_marker);
		send_prefix(PACK_START_CODE);
		send_byte({4'b0010, scr[32:30], !bad_marker});
		send_byte(scr[29:22]);
		send_byte({scr[21:15], 1'b1});
		send_byte(scr[14:7]);
		send_byte({scr[6:0], 1'b1});
		send_byte({1'b1, mux[21:15]});
		send_byte(mux[14:7]);
		send_byte({mux[6:0], 1'b1});
	endtask

	task automatic send_sys(input sys_info_t f, input int n);
		send_prefix(SYS_START_CODE);
		send_byte(f.header_length[15:8]);
		send_byte(f.header_length[7:0]);
		send_byte({1'b1, f.rate_bound[21:15]});
		send_byte(f.rate_bound[14:7]);
		send_byte({f.rate_bound[6:0], 1'b1});
		send_byte({f.audio_bound, f.fixed_flag, f.csps_flag});
		send_byte({f.audio_lock, f.video_lock, 1'b1, f.video_bound});
		send_byte(8'hFF);  // reserved
		for (int i = 0; i < n; i++) begin
			send_byte(ent_tab[i].stream_id);
			send_byte({2'b11, ent_tab[i].buf_scale, ent_tab[i].buf_size[12:8]});
			send_byte(ent_tab[i].buf_size[7:0]);
		end
	endtask

	// random fields with the entries in ent_tab
	function automatic sys_info_t make_sys(input int n);
		sys_info_t f;
		f = '0;
		f.header_length = hdr_len_t'(SYS_FIXED_BYTES + 3 * n);
		f.rate_bound    = mux_rate_t'(rand_bits(22));
		f.audio_bound   = 6'(rand_bits(6));
		f.video_bound   = 5'(rand_bits(5));
		f.fixed_flag    = 1'(rand_bits(1));
		f.csps_flag     = 1'(rand_bits(1));
		f.audio_lock    = 1'(rand_bits(1));
		f.video_lock    = 1'(rand_bits(1));
		f.marker_ok     = 1'b1;
		f.reserved_ok   = 1'b1;
		f.entry_count   = 8'(n);
		for (int i = 0; i < n; i++) begin
			ent_tab[i].stream_id = {1'b1, 7'(rand_bits(7))};
			ent_tab[i].buf_scale = 1'(rand_bits(1));
			ent_tab[i].buf_size  = buf_size_t'(rand_bits(13));
		end
		return f;
	endfunction

	task automatic clear_results();
		pack_q.delete();
		sys_q.delete();
		ent_q.delete();
		order_q.delete();
		start_cnt = 0;
	endtask

	task automatic wait_results(input int np, input int ne, input int ns);
		int n;
		n = 0;
		while (n < 200 && (pack_q.size() < np || ent_q.size() < ne || sys_q.size() < ns)) begin
			idle(1);
			n++;
		end
		require(pack_q.size() >= np && ent_q.size() >= ne && sys_q.size() >= ns,
			"timeout waiting for header results");
		idle(4);  // room for stray strobes
		compare_hex("pack_done count", 64'(pack_q.size()), 64'(np));
		compare_hex("stream_valid count", 64'(ent_q.size()), 64'(ne));
		compare_hex("sys_done count", 64'(sys_q.size()), 64'(ns));
	endtask

	task automatic check_sys(input sys_info_t exp, input int n);
		for (int i = 0; i < n; i++)
			compare_hex("stream_entry", 64'(ent_q[i]), 64'(ent_tab[i]));
		compare_hex("sys_info", 64'(sys_q[0]), 64'(exp));
		require(order_q[order_q.size() - 1] == 2, "sys_done came before a stream entry");
	endtask

	task automatic pack_fields();
		pack_info_t exp;
		clear_results();
		exp.scr       = scr_t'(rand_bits(33));
		exp.mux_rate  = mux_rate_t'(rand_bits(22));
		exp.marker_ok = 1'b1;
		send_pack(exp.scr, exp.mux_rate, 1'b0);
		wait_results(1, 0, 0);
		compare_hex("pack_info", 64'(pack_q[0]), 64'(exp));
	endtask

	task automatic pack_bad_marker();
		pack_info_t exp;
		clear_results();
		exp.scr       = scr_t'(rand_bits(33));
		exp.mux_rate  = mux_rate_t'(rand_bits(22));
		exp.marker_ok = 1'b0;
		send_pack(exp.scr, exp.mux_rate, 1'b1);
		wait_results(1, 0, 0);
		compare_hex("pack_info", 64'(pack_q[0]), 64'(exp));
	endtask

	task automatic sys_three_entries();
		sys_info_t exp;
		clear_results();
		exp = make_sys(3);
		send_sys(exp, 3);
		wait_results(0, 3, 1);
		check_sys(exp, 3);
	endtask

	task automatic prefix_cases();
		pack_info_t exp;
		clear_results();
		send_prefix(8'hE0);  // PES code without a header
		repeat (8) send_byte(8'h55);
		wait_results(0, 0, 0);
		require(start_cnt == 0, "start strobe after 00 00 01 E0");
		exp.scr       = scr_t'(rand_bits(33));
		exp.mux_rate  = mux_rate_t'(rand_bits(22));
		exp.marker_ok = 1'b1;
		repeat (4) send_byte(8'h00);  // six zeros with the prefix
		send_pack(exp.scr, exp.mux_rate, 1'b0);
		wait_results(1, 0, 0);
		require(start_cnt == 1, "long zero run did not give exactly one start strobe");
		compare_hex("pack_info", 64'(pack_q[0]), 64'(exp));
	endtask

	task automatic filler_pack_sys();
		pack_info_t pexp;
		sys_info_t  sexp;
		clear_results();
		repeat (5) send_byte(byte_t'(rand_bits(8)) | 8'h80);  // never 00
		pexp.scr       = scr_t'(rand_bits(33));
		pexp.mux_rate  = mux_rate_t'(rand_bits(22));
		pexp.marker_ok = 1'b1;
		sexp = make_sys(2);
		send_pack(pexp.scr, pexp.mux_rate, 1'b0);
		send_sys(sexp, 2);
		wait_results(1, 2, 1);
		compare_hex("pack_info", 64'(pack_q[0]), 64'(pexp));
		require(order_q[0] == 0, "pack header result did not come first");
		check_sys(sexp, 2);
	endtask

	task automatic reset_mid_header();
		sys_info_t exp;
		clear_results();
		send_prefix(SYS_START_CODE);
		send_byte(8'h00);
		send_byte(8'h0F);
		send_byte(8'hA5);
		send_bit(1'b1);  // part of a byte
		send_bit(1'b0);
		send_bit(1'b1);
		rst = 1'b1;
		idle(3);
		compare_hex("pack_info", 64'(pack_info), 64'h0);
		compare_hex("sys_info", 64'(sys_info), 64'h0);
		compare_hex("stream_entry", 64'(stream_entry), 64'h0);
		rst = 1'b0;
		clear_results();
		exp = make_sys(2);
		send_sys(exp, 2);
		wait_results(0, 2, 1);
		check_sys(exp, 2);
	endtask

	initial begin
		enable    = 1'b0;
		rst       = 1'b1;
		bit_in    = 1'b0;
		bit_valid = 1'b0;
		lfsr      = 32'h19e2f7ed;
		checks    = 0;
		errors    = 0;
		start_cnt = 0;
		repeat (10) @(posedge enable);
		#1;
		rst = 1'b0;
		idle(2);
		pack_fields();
		pack_bad_marker();
		sys_three_entries();
		prefix_cases();
		filler_pack_sys();
		reset_mid_header();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: common/mpeg_sys_pkg.sv
// package: stream field types, pack and system header structs, start-code constants

package mpeg_sys_pkg;

	typedef logic [7:0]  byte_t;      // one stream byte
	typedef logic [32:0] scr_t;       // system clock reference
	typedef logic [21:0] mux_rate_t;  // mux rate, also rate bound
	typedef logic [15:0] hdr_len_t;   // system header length
	typedef logic [7:0]  stream_id_t;
	typedef logic [12:0] buf_size_t;  // P-STD buffer size bound

	// pack header result, 56 bits
	typedef struct packed {
		scr_t      scr;
		mux_rate_t mux_rate;
		logic      marker_ok;
	} pack_info_t;

	// system header result, 63 bits
	typedef struct packed {
		hdr_len_t    header_length;
		mux_rate_t   rate_bound;
		logic [5:0]  audio_bound;
		logic [4:0]  video_bound;
		logic        fixed_flag;
		logic        csps_flag;
		logic        audio_lock;
		logic        video_lock;
		logic        marker_ok;
		logic        reserved_ok;   // reserved byte was FF
		logic [7:0]  entry_count;
	} sys_info_t;

	// one stream entry of the system header, 22 bits
	typedef struct packed {
		stream_id_t stream_id;
		logic       buf_scale;
		buf_size_t  buf_size;
	} stream_entry_t;

	localparam byte_t PACK_START_CODE = 8'hBA;  // after 00 00 01
	localparam byte_t SYS_START_CODE  = 8'hBB;

	localparam int PACK_HDR_BYTES  = 8;  // pack header bytes after the code
	localparam int SYS_FIXED_BYTES = 6;  // system header bytes after length

endpackage

// File: header_parser/pack_header_parser.sv
// module pack_header_parser: eight pack header bytes to SCR, mux rate and marker status

`timescale 1ns/1ps

module pack_header_parser (
	input  logic                     enable,
	input  logic                     rst,
	input  mpeg_sys_pkg::byte_t      byte_data,
	input  logic                     byte_valid,
	input  logic                     pack_start,
	output logic                     pack_done,
	output mpeg_sys_pkg::pack_info_t pack_info
);

	import mpeg_sys_pkg::*;

	logic       armed;
	logic [2:0] idx;        // byte index within the header
	pack_info_t work;       // fields collected so far
	pack_info_t work_nxt;
	logic       mark_good;  // markers of the current byte

	// place the current byte into the SCR and mux rate fields
	always_comb begin
		work_nxt  = work;
		mark_good = 1'b1;
		case (idx)
			3'd0: begin
				work_nxt.scr[32:30] = byte_data[3:1];
				mark_good = (byte_data[7:4] == 4'b0010) && byte_data[0];
			end
			3'd1: work_nxt.scr[29:22] = byte_data;
			3'd2: begin
				work_nxt.scr[21:15] = byte_data[7:1];
				mark_good = byte_data[0];
			end
			3'd3: work_nxt.scr[14:7] = byte_data;
			3'd4: begin
				work_nxt.scr[6:0] = byte_data[7:1];
				mark_good = byte_data[0];
			end
			3'd5: begin
				work_nxt.mux_rate[21:15] = byte_data[6:0];
				mark_good = byte_data[7];
			end
			3'd6: work_nxt.mux_rate[14:7] = byte_data;
			default: begin
				work_nxt.mux_rate[6:0] = byte_data[7:1];
				mark_good = byte_data[0];
			end
		endcase
		work_nxt.marker_ok = work.marker_ok & mark_good;
	end

	always_ff @(posedge enable) begin
		if (rst) begin
			armed     <= 1'b0;
			idx       <= 3'd0;
			pack_done <= 1'b0;
			pack_info <= '0;
		end else begin
			pack_done <= 1'b0;
			if (pack_start) begin  // restarts a header in progress too
				armed <= 1'b1;
				idx   <= 3'd0;
			end else if (armed && byte_valid) begin
				idx <= idx + 3'd1;
				if (idx == 3'(PACK_HDR_BYTES - 1)) begin
					armed     <= 1'b0;
					pack_done <= 1'b1;
					pack_info <= work_nxt;  // held until the next header
				end
			end
		end
	end

	// working copy of the fields
	always_ff @(posedge enable) begin
		if (pack_start) begin
			work           <= '0;
			work.marker_ok <= 1'b1;
		end else if (armed && byte_valid) begin
			work <= work_nxt;
		end
	end

endmodule

// File: header_parser/start_code_detector.sv
// module start_code_detector: 00 00 01 prefix search, pack and system header start strobes

`timescale 1ns/1ps

module start_code_detector (
	input  logic                enable,
	input  logic                rst,
	input  mpeg_sys_pkg::byte_t byte_data,
	input  logic                byte_valid,
	output logic                pack_start,
	output logic                sys_start
);

	import mpeg_sys_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_zero1,   // one 00 seen
		st_zero2,   // two or more 00 seen
		st_prefix   // 00 00 01 seen, code byte next
	} state_t;

	state_t state;
	state_t state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:
				if (byte_data == 8'h00)
					state_nxt = st_zero1;
			st_zero1:
				state_nxt = (byte_data == 8'h00) ? st_zero2 : st_idle;
			st_zero2: begin
				if (byte_data == 8'h01)
					state_nxt = st_prefix;
				else if (byte_data != 8'h00)
					state_nxt = st_idle;  // a run of zeros stays here
			end
			default:
				state_nxt = (byte_data == 8'h00) ? st_zero1 : st_idle;
		endcase
	end

	always_ff @(posedge enable) begin
		if (rst) begin
			state      <= st_idle;
			pack_start <= 1'b0;
			sys_start  <= 1'b0;
		end else begin
			pack_start <= 1'b0;
			sys_start  <= 1'b0;
			if (byte_valid) begin
				state <= state_nxt;
				if (state == st_prefix) begin
					pack_start <= (byte_data == PACK_START_CODE);
					sys_start  <= (byte_data == SYS_START_CODE);
				end
			end
		end
	end

endmodule

// File: header_parser/system_header_parser.sv
// module system_header_parser: system header fixed fields, stream entries and marker checks

`timescale 1ns/1ps

module system_header_parser (
	input  logic                        enable,
	input  logic                        rst,
	input  mpeg_sys_pkg::byte_t         byte_data,
	input  logic                        byte_valid,
	input  logic                        sys_start,
	output logic                        sys_done,
	output mpeg_sys_pkg::sys_info_t     sys_info,
	output logic                        stream_valid,
	output mpeg_sys_pkg::stream_entry_t stream_entry
);

	import mpeg_sys_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_length,  // two length bytes
		st_fixed,   // six fixed bytes
		st_entry    // 3-byte stream entries
	} state_t;

	state_t        state;
	logic [2:0]    idx;        // byte index within the current step
	hdr_len_t      rem;        // bytes left after the length field
	hdr_len_t      rem_dec;
	logic          last;       // current byte is the last one counted
	logic          done_now;   // finish on this byte
	logic          done_late;  // finish one cycle after the entry strobe
	logic          emit;       // third entry byte
	logic          pend;
	sys_info_t     work;
	sys_info_t     work_nxt;
	stream_entry_t ent;
	stream_entry_t ent_nxt;

	assign rem_dec = (rem != '0) ? rem - hdr_len_t'(1) : rem;  // saturates on short lengths
	assign last    = (rem <= hdr_len_t'(1));

	always_comb begin
		work_nxt  = work;
		ent_nxt   = ent;
		done_now  = 1'b0;
		done_late = 1'b0;
		emit      = 1'b0;
		case (state)
			st_length: begin
				if (idx == 3'd0)
					work_nxt.header_length[15:8] = byte_data;
				else
					work_nxt.header_length[7:0] = byte_data;
			end
			st_fixed: begin
				case (idx)
					3'd0: begin
						work_nxt.rate_bound[21:15] = byte_data[6:0];
						work_nxt.marker_ok = work.marker_ok & byte_data[7];
					end
					3'd1: work_nxt.rate_bound[14:7] = byte_data;
					3'd2: begin
						work_nxt.rate_bound[6:0] = byte_data[7:1];
						work_nxt.marker_ok = work.marker_ok & byte_data[0];
					end
					3'd3: begin
						work_nxt.audio_bound = byte_data[7:2];
						work_nxt.fixed_flag  = byte_data[1];
						work_nxt.csps_flag   = byte_data[0];
					end
					3'd4: begin
						work_nxt.audio_lock  = byte_data[7];
						work_nxt.video_lock  = byte_data[6];
						work_nxt.marker_ok   = work.marker_ok & byte_data[5];
						work_nxt.video_bound = byte_data[4:0];
					end
					default: begin
						work_nxt.reserved_ok = (byte_data == 8'hFF);
						done_now = last;  // header without entries
					end
				endcase
			end
			st_entry: begin
				case (idx)
					3'd0: begin
						ent_nxt.stream_id = byte_data;
						done_now = !byte_data[7] || last;  // bit 7 clear ends the list
					end
					3'd1: begin
						ent_nxt.buf_scale     = byte_data[5];
						ent_nxt.buf_size[12:8] = byte_data[4:0];
						done_now = last;  // truncated entry
					end
					default: begin
						ent_nxt.buf_size[7:0] = byte_data;
						emit      = 1'b1;
						done_late = last;
						work_nxt.entry_count = work.entry_count + 8'd1;
					end
				endcase
			end
			default: ;
		endcase
	end

	always_ff @(posedge enable) begin
		if (rst) begin
			state        <= st_idle;
			idx          <= 3'd0;
			rem          <= '0;
			pend         <= 1'b0;
			sys_done     <= 1'b0;
			sys_info     <= '0;
			stream_valid <= 1'b0;
			stream_entry <= '0;
		end else begin
			sys_done     <= pend;
			pend         <= 1'b0;
			stream_valid <= 1'b0;
			if (pend)
				sys_info <= work;  // entry count already includes the last entry
			if (sys_start) begin
				state <= st_length;
				idx   <= 3'd0;
			end else if (byte_valid && state != st_idle) begin
				idx <= idx + 3'd1;
				if (state != st_length)
					rem <= rem_dec;
				if (state == st_length && idx == 3'd1) begin
					rem   <= work_nxt.header_length;
					state <= st_fixed;
					idx   <= 3'd0;
				end
				if (state == st_fixed && idx == 3'(SYS_FIXED_BYTES - 1)) begin
					state <= st_entry;
					idx   <= 3'd0;
				end
				if (emit) begin
					idx          <= 3'd0;
					stream_valid <= 1'b1;
					stream_entry <= ent_nxt;
				end
				if (done_now) begin
					state    <= st_idle;
					sys_done <= 1'b1;
					sys_info <= work_nxt;
				end
				if (done_late) begin
					state <= st_idle;
					pend  <= 1'b1;  // keeps sys_done apart from stream_valid
				end
			end
		end
	end

	// working copies of the header fields and the current entry
	always_ff @(posedge enable) begin
		if (sys_start) begin
			work           <= '0;
			work.marker_ok <= 1'b1;
			ent            <= '0;
		end else if (byte_valid && state != st_idle) begin
			work <= work_nxt;
			ent  <= ent_nxt;
		end
	end

endmodule

// File: logic/bit_deserializer.sv
// module bit_deserializer: serial bit stream to byte strobes, MSB first

`timescale 1ns/1ps

module bit_deserializer (
	input  logic                enable,
	input  logic                rst,
	input  logic                bit_in,
	input  logic                bit_valid,
	output mpeg_sys_pkg::byte_t byte_data,
	output logic                byte_valid
);

	logic [6:0] shift;  // first seven bits of the current byte
	logic [2:0] bit_cnt;

	// control: bit counter and byte strobe
	always_ff @(posedge enable) begin
		if (rst) begin
			bit_cnt    <= 3'd0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (bit_valid) begin
				bit_cnt <= bit_cnt + 3'd1;  // wraps after the eighth bit
				if (bit_cnt == 3'd7)
					byte_valid <= 1'b1;
			end
		end
	end

	// payload path
	always_ff @(posedge enable) begin
		if (bit_valid) begin
			shift <= {shift[5:0], bit_in};
			if (bit_cnt == 3'd7)
				byte_data <= {shift, bit_in};  // last bit lands in the LSB
		end
	end

endmodule

// File: logic/mpeg_sys_parser.sv
// module mpeg_sys_parser: top level with deserializer, start-code detector and header parsers

`timescale 1ns/1ps

module mpeg_sys_parser (
	input  logic                        enable,
	input  logic                        rst,
	input  logic                        bit_in,
	input  logic                        bit_valid,
	output logic                        pack_done,
	output mpeg_sys_pkg::pack_info_t    pack_info,
	output logic                        sys_done,
	output mpeg_sys_pkg::sys_info_t     sys_info,
	output logic                        stream_valid,
	output mpeg_sys_pkg::stream_entry_t stream_entry
);

	import mpeg_sys_pkg::*;

	byte_t byte_data;   // to detector and both parsers
	logic  byte_valid;
	logic  pack_start;
	logic  sys_start;

	bit_deserializer bit_deserializer_inst (
		.enable     (enable),
		.rst        (rst),
		.bit_in     (bit_in),
		.bit_valid  (bit_valid),
		.byte_data  (byte_data),
		.byte_valid (byte_valid)
	);

	start_code_detector start_code_detector_inst (
		.enable     (enable),
		.rst        (rst),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.pack_start (pack_start),
		.sys_start  (sys_start)
	);

	pack_header_parser pack_header_parser_inst (
		.enable     (enable),
		.rst        (rst),
		.byte_data  (byte_data),
		.byte_valid (byte_valid),
		.pack_start (pack_start),
		.pack_done  (pack_done),
		.pack_info  (pack_info)
	);

	system_header_parser system_header_parser_inst (
		.enable       (enable),
		.rst          (rst),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.sys_start    (sys_start),
		.sys_done     (sys_done),
		.sys_info     (sys_info),
		.stream_valid (stream_valid),
		.stream_entry (stream_entry)
	);

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module mpeg_sys_parser_tb -f vlog.f \
	--Mdir obj_dir -o sim || { echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1 || echo "simulation exited with an error status" >> sim.log
cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: vlog.f
common/mpeg_sys_pkg.sv
logic/bit_deserializer.sv
header_parser/start_code_detector.sv
header_parser/pack_header_parser.sv
header_parser/system_header_parser.sv
logic/mpeg_sys_parser.sv
bench/mpeg_sys_parser_properties.sv
bench/mpeg_sys_parser_tb.sv
